/* compile.f */
rv_isa_pkg.sv
frontend_pkg.sv
fetch_if.sv
fetch_unit.sv
instruction_queue.sv
rv_decode.sv
frontend_top.sv
tb_checker.sv
tb_frontend.sv

/* fetch_if.sv */
`timescale 1ns/1ps
`default_nettype none

// link between the fetch stage and the instruction queue
interface fetch_if;
  import frontend_pkg::*;
  import rv_isa_pkg::*;

  // push strobe and the metadata that goes with it
  logic                   move_fetch;
  fetch_entry_t           entry;
  // memory answer, already filtered by fetch
  logic                   resp;
  logic [instr_width-1:0] rdata;
  // queue state and the strobes that come from the top level
  logic                   full;
  logic                   pop;
  logic                   flush;

  // fetch needs pop so it can push into a full queue that is draining
  modport fetch_side (output move_fetch, entry, resp, rdata, input full, pop);
  modport queue_side (input move_fetch, entry, resp, rdata, pop, flush, output full);

endinterface

`default_nettype wire

/* fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  redirect,
  input  logic [frontend_pkg::addr_width-1:0]   redirect_pc,
  input  logic [frontend_pkg::order_width-1:0]  redirect_order,
  output logic [frontend_pkg::addr_width-1:0]   imem_addr,
  output logic                                  imem_req,
  input  logic [rv_isa_pkg::instr_width-1:0]    imem_rdata,
  input  logic                                  imem_resp,
  fetch_if.fetch_side                           q
);
  import frontend_pkg::*;

  logic [addr_width-1:0]  fetch_pc;
  logic [addr_width-1:0]  pc_next;
  logic [order_width-1:0] fetch_order;
  // one request may be in flight at the memory
  logic                   pending;
  // set when the in-flight request was made before a redirect
  logic                   drop;
  // fetch starts one cycle after reset releases
  logic                   run;
  logic                   slot_free;
  logic                   can_push;
  logic                   req;

  // no branch prediction so the next pc is always the sequential one
  assign pc_next = fetch_pc + addr_width'(4);

  // the memory port is free when idle or when the answer lands this cycle
  assign slot_free = !pending || imem_resp;
  // a full queue still takes a push in the cycle it pops
  assign can_push = !q.full || q.pop;
  // nothing is requested in a redirect cycle because the queue flushes at the edge
  assign req = run && !redirect && slot_free && can_push;

  assign imem_addr    = fetch_pc;
  assign imem_req     = req;
  assign q.move_fetch = req;
  assign q.entry      = '{pc: fetch_pc, pc_next: pc_next, order: fetch_order};

  // answers to requests from before a redirect never reach the queue
  assign q.resp  = imem_resp && !drop;
  assign q.rdata = imem_rdata;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      run         <= 1'b0;
      pending     <= 1'b0;
      drop        <= 1'b0;
      fetch_pc    <= reset_pc;
      fetch_order <= '0;
    end else begin
      run <= 1'b1;

      // a new request keeps the port busy even when the old answer arrives now
      if (req) begin
        pending <= 1'b1;
      end else if (imem_resp) begin
        pending <= 1'b0;
      end

      // an answer landing in the redirect cycle is flushed by the queue itself
      if (redirect && pending && !imem_resp) begin
        drop <= 1'b1;
      end else if (imem_resp) begin
        drop <= 1'b0;
      end

      // the redirect target is what the next request carries
      if (redirect) begin
        fetch_pc    <= redirect_pc;
        fetch_order <= redirect_order;
      end else if (req) begin
        fetch_pc    <= pc_next;
        fetch_order <= fetch_order + 1'b1;
      end
    end
  end

  // the memory only answers requests that fetch has actually made
  resp_has_request: assert property (@(posedge clk) disable iff (!rst_n)
    imem_resp |-> pending)
    else $error("imem_resp without an outstanding request");

endmodule

`default_nettype wire

/* frontend_pkg.sv */
`default_nettype none

// widths and records of the fetch path
package frontend_pkg;

  // the order number counts every fetched instruction since reset
  localparam int order_width = 64;
  localparam int addr_width  = 32;

  // first fetch address after reset
  localparam logic [addr_width-1:0] reset_pc = 32'h0000_1000;

  // metadata captured when the memory request goes out, 128 bits
  // the instruction word itself arrives later and is stored apart
  typedef struct packed {
    logic [addr_width-1:0]  pc;
    logic [addr_width-1:0]  pc_next;
    logic [order_width-1:0] order;
  } fetch_entry_t;

endpackage

`default_nettype wire

/* frontend_top.sv */
`timescale 1ns/1ps
`default_nettype none

module frontend_top #(
  parameter int depth_bits = 2
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  // instruction memory
  output logic [frontend_pkg::addr_width-1:0]   imem_addr,
  output logic                                  imem_req,
  input  logic [rv_isa_pkg::instr_width-1:0]    imem_rdata,
  input  logic                                  imem_resp,
  // redirect from the back end
  input  logic                                  redirect,
  input  logic [frontend_pkg::addr_width-1:0]   redirect_pc,
  input  logic [frontend_pkg::order_width-1:0]  redirect_order,
  // issue side
  input  logic                                  instr_pop,
  output logic                                  instr_valid,
  output logic                                  instr_ready,
  output logic [frontend_pkg::order_width-1:0]  issue_order,
  output logic [rv_isa_pkg::instr_width-1:0]    issue_instr,
  output logic [frontend_pkg::addr_width-1:0]   issue_pc,
  output logic [frontend_pkg::addr_width-1:0]   issue_pc_next,
  output logic [rv_isa_pkg::funct3_width-1:0]   issue_funct3,
  output logic [rv_isa_pkg::funct7_width-1:0]   issue_funct7,
  output logic [rv_isa_pkg::opcode_width-1:0]   issue_opcode,
  output logic [rv_isa_pkg::instr_width-1:0]    issue_imm,
  output logic [rv_isa_pkg::reg_width-1:0]      issue_rs1_s,
  output logic [rv_isa_pkg::reg_width-1:0]      issue_rs2_s,
  output logic [rv_isa_pkg::reg_width-1:0]      issue_rd_s
);
  import frontend_pkg::*;
  import rv_isa_pkg::*;

  fetch_entry_t issue_entry;
  decoded_t     dec;

  fetch_if fif ();

  // the top-level strobes reach the queue through the link
  assign fif.pop   = instr_pop;
  assign fif.flush = redirect;

  fetch_unit u_fetch (
    .clk            (clk),
    .rst_n          (rst_n),
    .redirect       (redirect),
    .redirect_pc    (redirect_pc),
    .redirect_order (redirect_order),
    .imem_addr      (imem_addr),
    .imem_req       (imem_req),
    .imem_rdata     (imem_rdata),
    .imem_resp      (imem_resp),
    .q              (fif.fetch_side)
  );

  instruction_queue #(
    .depth_bits (depth_bits)
  ) u_queue (
    .clk         (clk),
    .rst_n       (rst_n),
    .q           (fif.queue_side),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .issue_entry (issue_entry),
    .issue_instr (issue_instr)
  );

  // decode works on the queue head in the same cycle
  rv_decode u_decode (
    .instr (issue_instr),
    .dec   (dec)
  );

  // flatten the head record and the decoded fields onto the issue ports
  assign issue_order   = issue_entry.order;
  assign issue_pc      = issue_entry.pc;
  assign issue_pc_next = issue_entry.pc_next;
  assign issue_opcode  = dec.opcode;
  assign issue_funct3  = dec.funct3;
  assign issue_funct7  = dec.funct7;
  assign issue_imm     = dec.imm;
  assign issue_rs1_s   = dec.rs1;
  assign issue_rs2_s   = dec.rs2;
  assign issue_rd_s    = dec.rd;

endmodule

`default_nettype wire

/* instruction_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module instruction_queue #(
  parameter int depth_bits = 2
) (
  input  logic                               clk,
  input  logic                               rst_n,
  fetch_if.queue_side                        q,
  output logic                               instr_valid,
  output logic                               instr_ready,
  output frontend_pkg::fetch_entry_t         issue_entry,
  output logic [rv_isa_pkg::instr_width-1:0] issue_instr
);
  import frontend_pkg::*;
  import rv_isa_pkg::*;

  localparam int depth = 1 << depth_bits;

  // payload storage
  // metadata is written at request time and the word at response time
  fetch_entry_t           meta_arr  [depth];
  logic [instr_width-1:0] instr_arr [depth];

  // a slot is valid once requested and ready once its word has arrived
  logic [depth-1:0]      valid_flags;
  logic [depth-1:0]      ready_flags;
  logic [depth_bits-1:0] valid_head;
  logic [depth_bits-1:0] valid_tail;
  logic [depth_bits-1:0] ready_head;
  logic [depth_bits-1:0] ready_tail;

  // the queue is full when the next slot to request is still occupied
  assign q.full = valid_flags[valid_head];

  // both tails move together so they always name the same oldest slot
  assign instr_valid = valid_flags[valid_tail];
  assign instr_ready = ready_flags[ready_tail];

  // the issue side reads the oldest slot directly
  assign issue_entry = meta_arr[ready_tail];
  assign issue_instr = instr_arr[ready_tail];

  // pointer and flag state
  always_ff @(posedge clk) begin
    if (!rst_n || q.flush) begin
      valid_flags <= '0;
      ready_flags <= '0;
      valid_head  <= '0;
      valid_tail  <= '0;
      ready_head  <= '0;
      ready_tail  <= '0;
    end else begin
      // the pop goes first so a push into the freed slot wins on a full queue
      if (q.pop) begin
        valid_flags[valid_tail] <= 1'b0;
        ready_flags[ready_tail] <= 1'b0;
        valid_tail              <= valid_tail + 1'b1;
        ready_tail              <= ready_tail + 1'b1;
      end

      if (q.move_fetch) begin
        valid_flags[valid_head] <= 1'b1;
        valid_head              <= valid_head + 1'b1;
      end

      // responses come back in request order so the ready head just follows
      if (q.resp) begin
        ready_flags[ready_head] <= 1'b1;
        ready_head              <= ready_head + 1'b1;
      end
    end
  end

  // payload writes
  // stale contents are harmless because the flags say what is live
  always_ff @(posedge clk) begin
    if (q.move_fetch) begin
      meta_arr[valid_head] <= q.entry;
    end
    if (q.resp) begin
      instr_arr[ready_head] <= q.rdata;
    end
  end

  // fetch only pushes into a full queue when the issue side drains it that cycle
  push_not_full: assert property (@(posedge clk) disable iff (!rst_n || q.flush)
    q.move_fetch |-> (!q.full || q.pop))
    else $error("push into a full queue without a pop");

  // the issue side may only take a slot whose word is present
  pop_when_ready: assert property (@(posedge clk) disable iff (!rst_n || q.flush)
    q.pop |-> instr_ready)
    else $error("pop while the head instruction is not ready");

  // a response needs a requested slot that still waits for its word
  resp_has_slot: assert property (@(posedge clk) disable iff (!rst_n || q.flush)
    q.resp |-> (ready_head != valid_head))
    else $error("response with no slot waiting for it");

endmodule

`default_nettype wire

/* rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
  input  logic [rv_isa_pkg::instr_width-1:0] instr,
  output rv_isa_pkg::decoded_t               dec
);
  import rv_isa_pkg::*;

  logic [opcode_width-1:0] opcode;

  assign opcode = instr[6:0];

  always_comb begin
    // the fixed fields sit at the same bits in every format
    dec.opcode = opcode;
    dec.rd     = instr[11:7];
    dec.funct3 = instr[14:12];
    dec.rs1    = instr[19:15];
    dec.rs2    = instr[24:20];
    dec.funct7 = instr[31:25];

    // the immediate depends on the format that the opcode selects
    // bit 31 is always the sign bit
    unique case (opcode)
      op_load, op_imm, op_jalr: begin
        // I format
        dec.imm = {{20{instr[31]}}, instr[31:20]};
      end
      op_store: begin
        // S format splits the immediate around rd's position
        dec.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      op_br: begin
        // B format is a halfword offset with scrambled upper bits
        dec.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      op_lui, op_auipc: begin
        // U format fills the upper 20 bits
        dec.imm = {instr[31:12], 12'h000};
      end
      op_jal: begin
        // J format with a 21-bit halfword offset
        dec.imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      op_reg: begin
        // register operations carry no immediate
        dec.imm = '0;
      end
      default: begin
        dec.imm = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* rv_isa_pkg.sv */
`default_nettype none

// RV32I encoding facts shared by the decoder and the queue
package rv_isa_pkg;

  // every base instruction is one 32-bit word
  localparam int instr_width = 32;

  // widths of the fixed fields in the instruction word
  localparam int opcode_width = 7;
  localparam int funct3_width = 3;
  localparam int funct7_width = 7;
  localparam int reg_width    = 5;

  // major opcodes of the base integer set, bits [6:0] of the word
  localparam logic [opcode_width-1:0] op_lui   = 7'b0110111;
  localparam logic [opcode_width-1:0] op_auipc = 7'b0010111;
  localparam logic [opcode_width-1:0] op_jal   = 7'b1101111;
  localparam logic [opcode_width-1:0] op_jalr  = 7'b1100111;
  localparam logic [opcode_width-1:0] op_br    = 7'b1100011;
  localparam logic [opcode_width-1:0] op_load  = 7'b0000011;
  localparam logic [opcode_width-1:0] op_store = 7'b0100011;
  localparam logic [opcode_width-1:0] op_imm   = 7'b0010011;
  localparam logic [opcode_width-1:0] op_reg   = 7'b0110011;

  // decoded view of one instruction, 64 bits in total
  // the immediate is already sign extended for its format
  typedef struct packed {
    logic [opcode_width-1:0] opcode;
    logic [funct3_width-1:0] funct3;
    logic [funct7_width-1:0] funct7;
    logic [reg_width-1:0]    rs1;
    logic [reg_width-1:0]    rs2;
    logic [reg_width-1:0]    rd;
    logic [instr_width-1:0]  imm;
  } decoded_t;

endpackage

`default_nettype wire

/* tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_checker #(
  parameter int depth_bits = 2
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  imem_req,
  input  logic [frontend_pkg::addr_width-1:0]   imem_addr,
  input  logic                                  redirect,
  input  logic [frontend_pkg::addr_width-1:0]   redirect_pc,
  input  logic [frontend_pkg::order_width-1:0]  redirect_order,
  input  logic                                  instr_pop,
  input  logic                                  instr_valid,
  input  logic                                  instr_ready,
  input  logic [frontend_pkg::order_width-1:0]  issue_order,
  input  logic [rv_isa_pkg::instr_width-1:0]    issue_instr,
  input  logic [frontend_pkg::addr_width-1:0]   issue_pc,
  input  logic [frontend_pkg::addr_width-1:0]   issue_pc_next,
  input  logic [rv_isa_pkg::funct3_width-1:0]   issue_funct3,
  input  logic [rv_isa_pkg::funct7_width-1:0]   issue_funct7,
  input  logic [rv_isa_pkg::opcode_width-1:0]   issue_opcode,
  input  logic [rv_isa_pkg::instr_width-1:0]    issue_imm,
  input  logic [rv_isa_pkg::reg_width-1:0]      issue_rs1_s,
  input  logic [rv_isa_pkg::reg_width-1:0]      issue_rs2_s,
  input  logic [rv_isa_pkg::reg_width-1:0]      issue_rd_s,
  // memory word at the expected pc, supplied by the memory model
  input  logic [rv_isa_pkg::instr_width-1:0]    expected_word,
  input  int                                    test_id,
  output logic [frontend_pkg::addr_width-1:0]   exp_pc,
  output int                                    errors,
  output int                                    checks
);
  import frontend_pkg::*;
  import rv_isa_pkg::*;

  localparam int depth = 1 << depth_bits;

  logic [order_width-1:0] exp_order;
  // requested slots that have not been popped or flushed
  int                     occupancy;
  int                     reset_edges;
  bit                     first_req;
  int                     cur_test;
  int                     test_checks;
  int                     test_errors;

  initial begin
    errors      = 0;
    checks      = 0;
    reset_edges = 0;
    occupancy   = 0;
    first_req   = 1'b1;
    cur_test    = 1;
    test_checks = 0;
    test_errors = 0;
    exp_pc      = reset_pc;
    exp_order   = '0;
  end

  function automatic string test_name(input int id);
    case (id)
      1: return "reset state";
      2: return "in-order stream and decode";
      3: return "back-pressure";
      4: return "redirect";
      default: return "unknown";
    endcase
  endfunction

  // RV32I field split written from the ISA manual, immediates built by arithmetic shifts
  function automatic decoded_t ref_decode(input logic [31:0] w);
    decoded_t           d;
    logic signed [31:0] sw;
    logic [31:0]        s20;
    logic [31:0]        s25;
    logic [31:0]        s31;
    sw  = w;
    s20 = sw >>> 20;
    s25 = sw >>> 25;
    s31 = sw >>> 31;
    d.opcode = w[6:0];
    d.rd     = w[11:7];
    d.funct3 = w[14:12];
    d.rs1    = w[19:15];
    d.rs2    = w[24:20];
    d.funct7 = w[31:25];
    case (w[6:0])
      op_load, op_imm, op_jalr: d.imm = s20;
      op_store: d.imm = (s25 << 5) | 32'(w[11:7]);
      op_br: d.imm = (s31 << 12) | (32'(w[7]) << 11) | (32'(w[30:25]) << 5)
                     | (32'(w[11:8]) << 1);
      op_lui, op_auipc: d.imm = w & 32'hffff_f000;
      op_jal: d.imm = (s31 << 20) | (32'(w[19:12]) << 12) | (32'(w[20]) << 11)
                      | (32'(w[30:21]) << 1);
      default: d.imm = '0;
    endcase
    return d;
  endfunction

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] want);
    checks++;
    test_checks++;
    if (got !== want) begin
      errors++;
      test_errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, want);
    end
  endtask

  // everything the issue side sees for one popped entry
  task automatic check_head();
    decoded_t d;
    d = ref_decode(expected_word);
    compare("instr_valid", instr_valid, 1);
    compare("issue_pc", issue_pc, exp_pc);
    compare("issue_pc_next", issue_pc_next, exp_pc + 32'd4);
    compare("issue_order", issue_order, exp_order);
    compare("issue_instr", issue_instr, expected_word);
    compare("issue_opcode", issue_opcode, d.opcode);
    compare("issue_funct3", issue_funct3, d.funct3);
    compare("issue_funct7", issue_funct7, d.funct7);
    compare("issue_rs1_s", issue_rs1_s, d.rs1);
    compare("issue_rs2_s", issue_rs2_s, d.rs2);
    compare("issue_rd_s", issue_rd_s, d.rd);
    compare("issue_imm", issue_imm, d.imm);
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      // the first edge only loads the reset values
      if (reset_edges > 0) begin
        compare("imem_req", imem_req, 0);
        compare("instr_valid", instr_valid, 0);
        compare("instr_ready", instr_ready, 0);
      end
      reset_edges++;
      exp_pc    = reset_pc;
      exp_order = '0;
      occupancy = 0;
      first_req = 1'b1;
    end else begin
      if (imem_req && first_req) begin
        compare("imem_addr", imem_addr, reset_pc);
        first_req = 1'b0;
      end
      // a full queue only takes a request in a cycle that also pops
      if (imem_req && occupancy >= depth && !instr_pop) begin
        errors++;
        test_errors++;
        $display("imem_req went out at %0t ns while the queue held %0d entries and nothing popped",
                 $time, occupancy);
      end
      // a redirect flushes everything and restarts the expected sequence
      if (redirect) begin
        exp_pc    = redirect_pc;
        exp_order = redirect_order;
        occupancy = 0;
      end else begin
        occupancy = occupancy + int'(imem_req) - int'(instr_pop);
        if (instr_pop) begin
          check_head();
          exp_pc    = exp_pc + 32'd4;
          exp_order = exp_order + 64'd1;
        end
      end
    end

    if (test_id != cur_test) begin
      // the back-pressure phase ends with the queue exactly full
      if (cur_test == 3) begin
        compare("queue occupancy", occupancy, depth);
      end
      $display("test %0d %s done with %0d checks and %0d errors",
               cur_test, test_name(cur_test), test_checks, test_errors);
      cur_test    = test_id;
      test_checks = 0;
      test_errors = 0;
    end
  end

endmodule

`default_nettype wire

/* tb_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_frontend;
  import frontend_pkg::*;
  import rv_isa_pkg::*;

  localparam int depth_bits = 2;

  logic                    clk;
  logic                    rst_n;
  logic [addr_width-1:0]   imem_addr;
  logic                    imem_req;
  logic [instr_width-1:0]  imem_rdata;
  logic                    imem_resp;
  logic                    redirect;
  logic [addr_width-1:0]   redirect_pc;
  logic [order_width-1:0]  redirect_order;
  logic                    instr_pop;
  logic                    instr_valid;
  logic                    instr_ready;
  logic [order_width-1:0]  issue_order;
  logic [instr_width-1:0]  issue_instr;
  logic [addr_width-1:0]   issue_pc;
  logic [addr_width-1:0]   issue_pc_next;
  logic [funct3_width-1:0] issue_funct3;
  logic [funct7_width-1:0] issue_funct7;
  logic [opcode_width-1:0] issue_opcode;
  logic [instr_width-1:0]  issue_imm;
  logic [reg_width-1:0]    issue_rs1_s;
  logic [reg_width-1:0]    issue_rs2_s;
  logic [reg_width-1:0]    issue_rd_s;
  // shared with the checker
  logic [addr_width-1:0]   exp_pc;
  logic [instr_width-1:0]  expected_word;
  int                      test_id;
  int                      errors;
  int                      checks;
  // stimulus state
  logic [15:0]             lfsr;
  int                      mem_left;
  logic [addr_width-1:0]   mem_addr;
  int                      pops_done;
  int                      idle_cycles;
  bit                      pop_on;
  bit                      redir_on;
  logic                    req_seen;
  logic [addr_width-1:0]   addr_seen;
  logic [15:0]             coin;

  frontend_top #(.depth_bits(depth_bits)) uut (.*);
  tb_checker #(.depth_bits(depth_bits)) chk (.*);

  always #20 clk = ~clk;

  // Galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hb400;
    end
    return s >> 1;
  endfunction

  // one LFSR step for every bit handed out
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[14:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return r;
  endfunction

  function automatic logic [6:0] opcode_at(input int idx);
    case (idx)
      0: return op_lui;
      1: return op_auipc;
      2: return op_jal;
      3: return op_jalr;
      4: return op_br;
      5: return op_load;
      6: return op_store;
      7: return op_imm;
      default: return op_reg;
    endcase
  endfunction

  // memory contents are scrambled from the whole address with a valid opcode on top
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [15:0] s;
    logic [31:0] w;
    s = addr[31:16] ^ addr[15:0] ^ 16'h6b3d;
    w = '0;
    if (s == 16'h0000) begin
      s = 16'h0001;
    end
    for (int i = 0; i < 32; i++) begin
      w = {w[30:0], s[0]};
      s = lfsr_next(s);
    end
    return {w[31:7], opcode_at(int'(addr[31:2] % 9))};
  endfunction

  assign expected_word = mem_word(exp_pc);

  // the memory model and the issue side drive their inputs 2 ns after the edge
  always @(posedge clk) begin
    // values held through the cycle that just ended
    req_seen  = imem_req;
    addr_seen = imem_addr;
    if (instr_pop) begin
      pops_done++;
    end
    if (imem_req) begin
      idle_cycles = 0;
    end else begin
      idle_cycles++;
    end
    #2;
    imem_resp = 1'b0;
    // latency of 1 to 4 cycles counted from the request cycle
    if (req_seen) begin
      mem_addr = addr_seen;
      mem_left = int'(rand_bits(2));
    end else if (mem_left > 0) begin
      mem_left--;
    end
    if (mem_left == 0) begin
      imem_resp  = 1'b1;
      imem_rdata = mem_word(mem_addr);
      mem_left   = -1;
    end
    coin     = rand_bits(4);
    redirect = redir_on && (coin[3:0] == 4'h0);
    if (redirect) begin
      redirect_pc    = 32'h0000_4000 + (32'(rand_bits(10)) << 2);
      redirect_order = 64'(rand_bits(16)) << 20;
    end
    coin      = rand_bits(1);
    instr_pop = pop_on && !redirect && instr_ready && coin[0];
  end

  // polls one cycle at a time until enough pops or a long fetch stall
  task automatic wait_for(input bit stall, input int target, input string what);
    int   n;
    logic done;
    n    = 0;
    done = 1'b0;
    while (!done && n < 1000) begin
      @(posedge clk);
      #1;
      n++;
      done = stall ? (idle_cycles >= 12) : (pops_done >= target);
    end
    if (!done) begin
      $display("timeout after 1000 cycles waiting for %s", what);
      $display("Result: FAILED");
      $finish;
    end
  endtask

  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    imem_rdata     = '0;
    imem_resp      = 1'b0;
    redirect       = 1'b0;
    redirect_pc    = '0;
    redirect_order = '0;
    instr_pop      = 1'b0;
    lfsr           = 16'd38557;
    mem_left       = -1;
    mem_addr       = '0;
    pops_done      = 0;
    idle_cycles    = 0;
    pop_on         = 1'b1;
    redir_on       = 1'b0;
    test_id        = 1;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    wait_for(1'b0, 1, "the first instruction");
    test_id = 2;
    wait_for(1'b0, pops_done + 40, "the random stream");
    // hold pops off until fetch gives up requesting
    test_id = 3;
    pop_on  = 1'b0;
    wait_for(1'b1, 0, "fetch to stall on a full queue");
    test_id = 4;
    @(posedge clk);
    #1;
    pop_on = 1'b1;
    // the entries held back by the full queue come out in order first
    wait_for(1'b0, pops_done + (1 << depth_bits), "the full queue to drain");
    redir_on = 1'b1;
    wait_for(1'b0, pops_done + 60, "pops across redirects");
    redir_on = 1'b0;
    pop_on   = 1'b0;
    test_id  = 5;
    repeat (2) @(posedge clk);
    #1;
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
